/* all.f */
wino_arith_pkg.sv
wino_tile_pkg.sv
wino_adder_tree.sv
wino_step_counter.sv
wino_drain_fsm.sv
wino_column_transform.sv
wino_tile_buffer.sv
wino_row_transform.sv
wino_inverse_top.sv
wino_inverse_properties.sv
tb_wino_inverse.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_wino_inverse
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_wino_inverse.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_wino_inverse;

	localparam int OUT_DELAY = 2;
	localparam int NT = 11;
	localparam int AT [4][6] = '{
		'{1, 1, 1, 1, 1, 0},
		'{0, 1, -1, 2, -2, 0},
		'{0, 1, 1, 4, 4, 0},
		'{0, 1, -1, 8, -8, 1}
	};

	logic clk = 1'b0;
	logic i_reset;
	logic i_valid;
	wino_tile_pkg::tile_col_t i_col;
	logic o_valid;
	wino_tile_pkg::out_row_t o_row;
	logic [1:0] o_row_idx;

	// Test table with input words indexed [test][row][column].
	string t_name [NT];
	wino_arith_pkg::acc_t t_x [NT][6][6];
	wino_tile_pkg::out_row_t t_exp [NT][4];
	int t_gap [NT][6];
	int t_pre_reset [NT];

	wino_tile_pkg::out_row_t exp_q [$];
	int exp_test_q [$];
	int exp_idx_q [$];
	int exp_cyc_q [$];
	int test_err [NT];
	int cyc = 0;
	int limit = 0;
	int errors = 0;
	int checks = 0;
	int tests_done = 0;
	int tests_failed = 0;
	int cur_test = 0;
	logic [31:0] rng = 32'h8ea1_3625;

	wino_inverse_top #(.OUT_DELAY(OUT_DELAY)) dut0 (
		.clk(clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_col(i_col),
		.o_valid(o_valid),
		.o_row(o_row),
		.o_row_idx(o_row_idx)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Reference model applies AT down each column, then along each row.
	function automatic wino_tile_pkg::out_row_t model_row(input int k, input int r);
		wino_arith_pkg::acc_t tf [6];
		wino_arith_pkg::acc_t s;
		wino_arith_pkg::acc_word_u w;
		wino_arith_pkg::pixel_t px [4];
		for (int j = 0; j < 6; j++) begin
			tf[j] = '0;
			for (int i = 0; i < 6; i++) begin
				tf[j] = tf[j] + wino_arith_pkg::acc_t'(AT[r][i]) * t_x[k][i][j];
			end
		end
		for (int c = 0; c < 4; c++) begin
			s = '0;
			for (int j = 0; j < 6; j++) begin
				s = s + wino_arith_pkg::acc_t'(AT[c][j]) * tf[j];
			end
			w.sum = s;
			px[c] = w.fields.sign ? '0 : w.fields.value;
		end
		return '{px[0], px[1], px[2], px[3]};
	endfunction

	task automatic fill_table();
		int total;
		for (int k = 0; k < NT; k++) begin
			t_pre_reset[k] = 0;
			for (int n = 0; n < 6; n++) begin
				t_gap[k][n] = 0;
				for (int m = 0; m < 6; m++) begin
					t_x[k][n][m] = '0;
				end
			end
			for (int r = 0; r < 4; r++) begin
				t_exp[k][r] = '0;
			end
		end
		t_name[0] = "impulse_0_0";
		t_x[0][0][0] = 30'sd256;
		t_exp[0][0] = 64'h0001_0000_0000_0000;
		t_name[1] = "impulse_3_4";
		t_x[1][3][4] = 30'sd256;
		t_exp[1][0] = 64'h0001_0000_0004_0000;
		t_exp[1][1] = 64'h0002_0000_0008_0000;
		t_exp[1][2] = 64'h0004_0000_0010_0000;
		t_exp[1][3] = 64'h0008_0000_0020_0000;
		t_name[2] = "impulse_2_1";
		t_x[2][2][1] = 30'sd256;
		t_exp[2][0] = 64'h0001_0001_0001_0001;
		t_exp[2][2] = 64'h0001_0001_0001_0001;
		t_name[3] = "impulse_5_5";
		t_x[3][5][5] = 30'sd256;
		t_exp[3][3] = 64'h0000_0000_0000_0001;
		// Every sum is negative, so all pixels clip.
		t_name[4] = "rect_negative";
		t_x[4][0][0] = -30'sd256;
		t_x[4][3][3] = -30'sd512;
		t_name[5] = "rect_high_bits";
		t_x[5][0][0] = 30'sh0ABC_DE12;
		t_exp[5][0] = 64'hBCDE_0000_0000_0000;
		t_name[6] = "random_a";
		t_name[7] = "random_gaps_a";
		t_name[8] = "random_small";
		t_name[9] = "random_gaps_b";
		t_name[10] = "reset_mid_tile";
		t_gap[7] = '{1, 0, 2, 0, 3, 1};
		t_gap[9] = '{0, 4, 0, 1, 0, 0};
		t_gap[10] = '{0, 0, 1, 0, 0, 0};
		t_pre_reset[10] = 3;
		for (int k = 6; k < NT; k++) begin
			for (int n = 0; n < 6; n++) begin
				for (int m = 0; m < 6; m++) begin
					t_x[k][n][m] = wino_arith_pkg::acc_t'(next_random());
					if (k == 8) begin
						t_x[k][n][m] = t_x[k][n][m] >>> 8;
					end
				end
			end
			for (int r = 0; r < 4; r++) begin
				t_exp[k][r] = model_row(k, r);
			end
		end
		total = 3;
		for (int k = 0; k < NT; k++) begin
			total = total + 6 + t_pre_reset[k] + (t_pre_reset[k] > 0 ? 3 : 0);
			for (int n = 0; n < 6; n++) begin
				total = total + t_gap[k][n];
			end
		end
		limit = 4 * total + 100;
	endtask

	task automatic check_row(
		input string name,
		input wino_tile_pkg::out_row_t exp,
		input wino_tile_pkg::out_row_t act
	);
		checks++;
		if (act !== exp) begin
			$display("** Error: %s row pixels: expected %h, actual %h", name, exp, act);
			errors++;
			test_err[cur_test]++;
		end
	endtask

	task automatic check_index(input string name, input logic [1:0] exp, input logic [1:0] act);
		checks++;
		if (act !== exp) begin
			$display("** Error: %s row index: expected %0d, actual %0d", name, exp, act);
			errors++;
			test_err[cur_test]++;
		end
	endtask

	task automatic wait_drained();
		@(negedge clk);
		i_valid = 1'b0;
		while (exp_q.size() > 0) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic drive_tile(input int k);
		for (int n = 0; n < t_pre_reset[k]; n++) begin
			@(negedge clk);
			i_valid = 1'b1;
			i_col = {6{wino_arith_pkg::acc_t'(next_random())}};
		end
		// Partial columns are dropped by the reset.
		if (t_pre_reset[k] > 0) begin
			@(negedge clk);
			i_valid = 1'b0;
			i_reset = 1'b1;
			repeat (3) @(negedge clk);
			i_reset = 1'b0;
		end
		for (int j = 0; j < 6; j++) begin
			@(negedge clk);
			i_valid = 1'b1;
			i_col = '{t_x[k][0][j], t_x[k][1][j], t_x[k][2][j],
				t_x[k][3][j], t_x[k][4][j], t_x[k][5][j]};
			if (j == 5) begin
				for (int r = 0; r < 4; r++) begin
					exp_q.push_back(t_exp[k][r]);
					exp_test_q.push_back(k);
					exp_idx_q.push_back(r);
					exp_cyc_q.push_back(cyc + 8 + OUT_DELAY + r);
				end
			end
			for (int g = 0; g < t_gap[k][j]; g++) begin
				@(negedge clk);
				i_valid = 1'b0;
			end
		end
	endtask

	always @(negedge clk) begin : monitor
		int idx;
		int exp_cyc;
		if (o_valid) begin
			if (exp_q.size() == 0) begin
				$display("Output row appeared at cycle %0d with no tile pending", cyc);
				errors++;
			end else begin
				cur_test = exp_test_q.pop_front();
				idx = exp_idx_q.pop_front();
				exp_cyc = exp_cyc_q.pop_front();
				check_row(t_name[cur_test], exp_q.pop_front(), o_row);
				check_index(t_name[cur_test], 2'(idx), o_row_idx);
				checks++;
				if (cyc != exp_cyc) begin
					$display("** Error: %s arrival cycle: expected %0d, actual %0d",
						t_name[cur_test], exp_cyc, cyc);
					errors++;
					test_err[cur_test]++;
				end
				if (idx == 3) begin
					tests_done++;
					if (test_err[cur_test] > 0) begin
						tests_failed++;
						$display("test %s: %0d errors", t_name[cur_test], test_err[cur_test]);
					end else begin
						$display("test %s: ok", t_name[cur_test]);
					end
				end
			end
		end
	end

	initial begin : watchdog
		@(posedge clk);
		while (cyc < limit) begin
			@(posedge clk);
		end
		$display("Timeout after %0d cycles with output rows still missing", cyc);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : stimulus
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_col = '0;
		fill_table();
		repeat (3) @(negedge clk);
		i_reset = 1'b0;
		for (int k = 0; k < NT; k++) begin
			if (t_pre_reset[k] > 0) begin
				wait_drained();
			end
			drive_tile(k);
		end
		wait_drained();
		repeat (12) @(negedge clk);
		$display("tests %0d of %0d, failed %0d, checks %0d, errors %0d",
			tests_done, NT, tests_failed, checks, errors);
		if (errors == 0 && tests_done == NT) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* wino_inverse_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module wino_inverse_properties (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_capture,
	input wire logic i_drain,
	input wire logic i_out_valid,
	input wire logic [1:0] i_out_row_idx
);

	// Four rows per drain.
	a_drain_len: assert property (@(posedge clk) disable iff (i_reset)
		$fell(i_drain) |-> $past(i_drain, 2) && $past(i_drain, 3) && $past(i_drain, 4)
			&& !$past(i_drain, 5))
		else $error("drain did not last four cycles");

	a_no_capture_in_drain: assert property (@(posedge clk) disable iff (i_reset)
		!(i_capture && i_drain))
		else $error("capture while draining");

	a_quiet_after_reset: assert property (@(posedge clk) i_reset |=> !i_out_valid)
		else $error("output valid right after reset");

	a_first_row: assert property (@(posedge clk) disable iff (i_reset)
		$rose(i_out_valid) |-> i_out_row_idx == 2'd0)
		else $error("tile did not start at row 0");

	a_row_step: assert property (@(posedge clk) disable iff (i_reset)
		i_out_valid && $past(i_out_valid) |-> i_out_row_idx == $past(i_out_row_idx) + 2'd1)
		else $error("row index skipped");

endmodule

bind wino_inverse_top wino_inverse_properties u_props (
	.clk(clk),
	.i_reset(i_reset),
	.i_capture(capture),
	.i_drain(drain),
	.i_out_valid(o_valid),
	.i_out_row_idx(o_row_idx)
);

`default_nettype wire

/* wino_inverse_top.sv */
`timescale 1ns/1ns
`default_nettype none

module wino_inverse_top #(
	parameter int OUT_DELAY = 2
) (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_valid,
	input wire wino_tile_pkg::tile_col_t i_col,
	output logic o_valid,
	output wino_tile_pkg::out_row_t o_row,
	output logic [1:0] o_row_idx
);

	wino_tile_pkg::tf_col_t tf_col;
	wino_tile_pkg::tile_row_t tile_row;
	logic col_valid;
	logic col_last;
	logic capture;
	logic drain;
	logic [1:0] row_idx;
	logic row_last;

	wino_column_transform u_col_tf (
		.clk(clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_col(i_col),
		.o_col(tf_col),
		.o_valid(col_valid)
	);

	// Only the last flag matters for the column position.
	wino_step_counter #(.WRAP(wino_tile_pkg::TILE_N)) col_cnt (
		.clk(clk),
		.i_reset(i_reset),
		.i_enable(col_valid),
		.o_count(),
		.o_last(col_last)
	);

	wino_drain_fsm u_fsm (
		.clk(clk),
		.i_reset(i_reset),
		.i_col_valid(col_valid),
		.i_col_last(col_last),
		.i_row_last(row_last),
		.o_capture(capture),
		.o_drain(drain)
	);

	wino_step_counter #(.WRAP(wino_tile_pkg::OUT_N)) row_cnt (
		.clk(clk),
		.i_reset(i_reset),
		.i_enable(drain),
		.o_count(row_idx),
		.o_last(row_last)
	);

	wino_tile_buffer u_buf (
		.clk(clk),
		.i_shift(col_valid),
		.i_capture(capture),
		.i_col(tf_col),
		.i_row_idx(row_idx),
		.o_row(tile_row)
	);

	wino_row_transform #(.OUT_DELAY(OUT_DELAY)) u_row_tf (
		.clk(clk),
		.i_reset(i_reset),
		.i_row(tile_row),
		.i_valid(drain),
		.i_row_idx(row_idx),
		.o_row(o_row),
		.o_valid(o_valid),
		.o_row_idx(o_row_idx)
	);

endmodule

`default_nettype wire

/* wino_row_transform.sv */
`timescale 1ns/1ns
`default_nettype none

module wino_row_transform #(
	parameter int OUT_DELAY = 2
) (
	input wire logic clk,
	input wire logic i_reset,
	input wire wino_tile_pkg::tile_row_t i_row,
	input wire logic i_valid,
	input wire logic [1:0] i_row_idx,
	output wino_tile_pkg::out_row_t o_row,
	output logic o_valid,
	output logic [1:0] o_row_idx
);

	// Three adder stages plus the rectify register.
	localparam int VLAT = 4 + OUT_DELAY;

	wino_arith_pkg::acc_t sums [wino_tile_pkg::OUT_N];
	wino_tile_pkg::out_row_t row_sr [OUT_DELAY+1];
	logic [VLAT-1:0] vld_sr;
	logic [1:0] idx_sr [VLAT];

	// Negative words clip to zero, others keep bits 23 to 8.
	function automatic wino_arith_pkg::pixel_t rectify(input wino_arith_pkg::acc_t sum);
		wino_arith_pkg::acc_word_u w;
		w.sum = sum;
		return w.fields.sign ? '0 : w.fields.value;
	endfunction

	for (genvar k = 0; k < wino_tile_pkg::OUT_N; k++) begin : g_tree
		wino_adder_tree u_tree (
			.clk(clk),
			.i_in(wino_tile_pkg::at_terms(i_row, k)),
			.o_sum(sums[k])
		);
	end

	always_ff @(posedge clk) begin
		row_sr[0] <= '{rectify(sums[0]), rectify(sums[1]), rectify(sums[2]), rectify(sums[3])};
		for (int s = 1; s <= OUT_DELAY; s++) begin
			row_sr[s] <= row_sr[s-1];
		end
		idx_sr[0] <= i_row_idx;
		for (int s = 1; s < VLAT; s++) begin
			idx_sr[s] <= idx_sr[s-1];
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[VLAT-2:0], i_valid};
		end
	end

	assign o_row = row_sr[OUT_DELAY];
	assign o_valid = vld_sr[VLAT-1];
	assign o_row_idx = idx_sr[VLAT-1];

endmodule

`default_nettype wire

/* wino_tile_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module wino_tile_buffer (
	input wire logic clk,
	input wire logic i_shift,
	input wire logic i_capture,
	input wire wino_tile_pkg::tf_col_t i_col,
	input wire logic [1:0] i_row_idx,
	output wino_tile_pkg::tile_row_t o_row
);

	// Newest held column at index 0.
	wino_tile_pkg::tf_col_t hold [wino_tile_pkg::TILE_N-1];
	// Captured tile in column order.
	wino_tile_pkg::tf_col_t cap [wino_tile_pkg::TILE_N];

	function automatic wino_arith_pkg::acc_t pick(
		input wino_tile_pkg::tf_col_t c,
		input logic [1:0] r
	);
		case (r)
			2'd0: pick = c.w0;
			2'd1: pick = c.w1;
			2'd2: pick = c.w2;
			default: pick = c.w3;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (i_shift) begin
			hold[0] <= i_col;
			for (int s = 1; s < wino_tile_pkg::TILE_N - 1; s++) begin
				hold[s] <= hold[s-1];
			end
		end
		if (i_capture) begin
			for (int c = 0; c < wino_tile_pkg::TILE_N - 1; c++) begin
				cap[c] <= hold[wino_tile_pkg::TILE_N-2-c];
			end
			cap[wino_tile_pkg::TILE_N-1] <= i_col;
		end
	end

	assign o_row = '{
		pick(cap[0], i_row_idx),
		pick(cap[1], i_row_idx),
		pick(cap[2], i_row_idx),
		pick(cap[3], i_row_idx),
		pick(cap[4], i_row_idx),
		pick(cap[5], i_row_idx)
	};

endmodule

`default_nettype wire

/* wino_column_transform.sv */
`timescale 1ns/1ns
`default_nettype none

module wino_column_transform (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_valid,
	input wire wino_tile_pkg::tile_col_t i_col,
	output wino_tile_pkg::tf_col_t o_col,
	output logic o_valid
);

	wino_tile_pkg::tile_row_t col_words;
	wino_arith_pkg::acc_t sums [wino_tile_pkg::OUT_N];
	logic [2:0] vld_sr;

	// Same word layout, so the column feeds the shared term builder.
	assign col_words = wino_tile_pkg::tile_row_t'(i_col);

	for (genvar k = 0; k < wino_tile_pkg::OUT_N; k++) begin : g_tree
		wino_adder_tree u_tree (
			.clk(clk),
			.i_in(wino_tile_pkg::at_terms(col_words, k)),
			.o_sum(sums[k])
		);
	end

	assign o_col = '{sums[0], sums[1], sums[2], sums[3]};

	// Strobe follows the three adder stages.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[1:0], i_valid};
		end
	end

	assign o_valid = vld_sr[2];

endmodule

`default_nettype wire

/* wino_drain_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module wino_drain_fsm (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_col_valid,
	input wire logic i_col_last,
	input wire logic i_row_last,
	output logic o_capture,
	output logic o_drain
);

	wino_tile_pkg::drain_state_e state;
	wino_tile_pkg::drain_state_e next_state;

	// Sixth transformed column of a tile is on the bus.
	assign o_capture = i_col_valid && i_col_last;
	assign o_drain = (state == wino_tile_pkg::DRAIN);

	always_comb begin
		next_state = state;
		case (state)
			wino_tile_pkg::IDLE: begin
				if (o_capture) begin
					next_state = wino_tile_pkg::DRAIN;
				end
			end
			wino_tile_pkg::DRAIN: begin
				if (i_row_last) begin
					next_state = wino_tile_pkg::IDLE;
				end
			end
			default: next_state = wino_tile_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= wino_tile_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

/* wino_step_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module wino_step_counter #(
	parameter int WRAP = 4
) (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_enable,
	output logic [$clog2(WRAP)-1:0] o_count,
	output logic o_last
);

	localparam int CNT_W = $clog2(WRAP);

	assign o_last = (o_count == CNT_W'(WRAP - 1));

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_count <= '0;
		end else if (i_enable) begin
			o_count <= o_last ? '0 : o_count + CNT_W'(1);
		end
	end

endmodule

`default_nettype wire

/* wino_adder_tree.sv */
`timescale 1ns/1ns
`default_nettype none

module wino_adder_tree (
	input wire logic clk,
	input wire wino_tile_pkg::tile_row_t i_in,
	output wino_arith_pkg::acc_t o_sum
);

	wino_arith_pkg::acc_t s1_a;
	wino_arith_pkg::acc_t s1_b;
	wino_arith_pkg::acc_t s1_c;
	wino_arith_pkg::acc_t s2_a;
	wino_arith_pkg::acc_t s2_b;

	// Sums wrap at the word width.
	always_ff @(posedge clk) begin
		s1_a <= i_in.w0 + i_in.w1;
		s1_b <= i_in.w2 + i_in.w3;
		s1_c <= i_in.w4 + i_in.w5;

		s2_a <= s1_a + s1_b;
		s2_b <= s1_c;

		o_sum <= s2_a + s2_b;
	end

endmodule

`default_nettype wire

/* wino_tile_pkg.sv */
`default_nettype none

package wino_tile_pkg;

	localparam int TILE_N = 6;
	localparam int OUT_N = 4;

	typedef struct packed {
		wino_arith_pkg::acc_t w0;
		wino_arith_pkg::acc_t w1;
		wino_arith_pkg::acc_t w2;
		wino_arith_pkg::acc_t w3;
		wino_arith_pkg::acc_t w4;
		wino_arith_pkg::acc_t w5;
	} tile_col_t;

	typedef struct packed {
		wino_arith_pkg::acc_t w0;
		wino_arith_pkg::acc_t w1;
		wino_arith_pkg::acc_t w2;
		wino_arith_pkg::acc_t w3;
	} tf_col_t;

	typedef struct packed {
		wino_arith_pkg::acc_t w0;
		wino_arith_pkg::acc_t w1;
		wino_arith_pkg::acc_t w2;
		wino_arith_pkg::acc_t w3;
		wino_arith_pkg::acc_t w4;
		wino_arith_pkg::acc_t w5;
	} tile_row_t;

	typedef struct packed {
		wino_arith_pkg::pixel_t p0;
		wino_arith_pkg::pixel_t p1;
		wino_arith_pkg::pixel_t p2;
		wino_arith_pkg::pixel_t p3;
	} out_row_t;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		DRAIN = 2'd1
	} drain_state_e;

	// Adder-tree inputs for row k of AT applied to six words.
	function automatic tile_row_t at_terms(input tile_row_t x, input int k);
		tile_row_t t;
		t = '0;
		t.w1 = x.w1;
		case (k)
			0: begin
				t.w0 = x.w0;
				t.w2 = x.w2;
				t.w3 = x.w3;
				t.w4 = x.w4;
			end
			1: begin
				t.w2 = -x.w2;
				t.w3 = x.w3 <<< 1;
				t.w4 = -(x.w4 <<< 1);
			end
			2: begin
				t.w2 = x.w2;
				t.w3 = x.w3 <<< 2;
				t.w4 = x.w4 <<< 2;
			end
			default: begin
				t.w2 = -x.w2;
				t.w3 = x.w3 <<< 3;
				t.w4 = -(x.w4 <<< 3);
				t.w5 = x.w5;
			end
		endcase
		return t;
	endfunction

endpackage

`default_nettype wire

/* wino_arith_pkg.sv */
`default_nettype none

package wino_arith_pkg;

	localparam int ACC_W = 30;
	localparam int PIX_W = 16;

	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [PIX_W-1:0] pixel_t;

	// Fixed-point fields of a result word from the msb down.
	typedef struct packed {
		logic sign;
		logic [4:0] high;
		logic [PIX_W-1:0] value;
		logic [7:0] frac;
	} acc_fields_t;

	// Same 30 bits seen as a wrapped sum or as pixel fields.
	typedef union packed {
		acc_t sum;
		acc_fields_t fields;
	} acc_word_u;

endpackage

`default_nettype wire
